// File: rtl/joint_loop_macros.svh
`ifndef JOINT_LOOP_MACROS_SVH
`define JOINT_LOOP_MACROS_SVH

//////////////////////////////////////////////////
// length buffer geometry
//////////////////////////////////////////////////

// address width of the sample memory
`define WAVE_AW 6

// number of sample slots
`define WAVE_DEPTH (1 << `WAVE_AW)

//////////////////////////////////////////////////
// host register reset values
//////////////////////////////////////////////////

// tick every 4 cycles
`define DEF_HALF_CNT 16'd4

// unity gain
`define DEF_GAIN 16'd1

// accumulator level that fires a spike
`define DEF_THRESHOLD 32'd1000

// updates per spike count report
`define DEF_WINDOW 16'd8

`endif

// File: rtl/joint_loop_pkg.sv
package joint_loop_pkg;

    //////////////////////////////////////////////////
    // host register addresses
    //////////////////////////////////////////////////

    // one address per trigger-loaded register
    typedef enum logic [3:0]
    {
        // tick period in cycles
        PA_HALF_CNT     = 4'd0,
        // neuron input gain
        PA_GAIN         = 4'd1,
        // spike threshold, {hi, lo}
        PA_THRESHOLD    = 4'd2,
        // fixed length used while override is on
        PA_LEN_OVERRIDE = 4'd3,
        // override enable, bit 0 of lo
        PA_OVERRIDE_EN  = 4'd4,
        // updates per count window
        PA_WINDOW       = 4'd5
    } param_addr_e;

    //////////////////////////////////////////////////
    // datapath types
    //////////////////////////////////////////////////

    // muscle length sample, unsigned
    typedef logic [15:0] sample_t;
    typedef logic [15:0] gain_t;
    // length times gain
    typedef logic [31:0] drive_t;
    typedef logic [15:0] count_t;

endpackage

// File: rtl/host_control.sv
`timescale 1ns/1ps

`include "joint_loop_macros.svh"

module host_control
(
    input  logic                      ep50trig,
    input  logic                      reset_global,
    input  logic                      i_trig_valid,
    input  joint_loop_pkg::param_addr_e i_trig_addr,
    input  logic [15:0]               i_wire_lo,
    input  logic [15:0]               i_wire_hi,
    output logic                      o_tick,
    output joint_loop_pkg::gain_t     o_gain,
    output logic [31:0]               o_threshold,
    output joint_loop_pkg::count_t    o_window,
    output logic                      o_override_en,
    output joint_loop_pkg::sample_t   o_override_len
);

    // tick period, only seen by the divider
    logic [15:0] half_cnt;
    logic [15:0] tick_cnt;
    // zero period behaves like one
    logic [15:0] period;
    logic        half_cnt_wr;

    //////////////////////////////////////////////////
    // trigger-loaded registers
    //////////////////////////////////////////////////

    // address decode on the strobe
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            half_cnt       <= `DEF_HALF_CNT;
            o_gain         <= `DEF_GAIN;
            o_threshold    <= `DEF_THRESHOLD;
            o_window       <= `DEF_WINDOW;
            o_override_en  <= 1'b0;
            o_override_len <= '0;
        end
        else if (i_trig_valid)
        begin
            case (i_trig_addr)
                joint_loop_pkg::PA_HALF_CNT:     half_cnt       <= i_wire_lo;
                joint_loop_pkg::PA_GAIN:         o_gain         <= i_wire_lo;
                joint_loop_pkg::PA_THRESHOLD:    o_threshold    <= {i_wire_hi, i_wire_lo};
                joint_loop_pkg::PA_LEN_OVERRIDE: o_override_len <= i_wire_lo;
                joint_loop_pkg::PA_OVERRIDE_EN:  o_override_en  <= i_wire_lo[0];
                joint_loop_pkg::PA_WINDOW:       o_window       <= i_wire_lo;
                // unknown address, nothing changes
                default:
                begin
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // simulation tick divider
    //////////////////////////////////////////////////

    assign half_cnt_wr = i_trig_valid && (i_trig_addr == joint_loop_pkg::PA_HALF_CNT);
    assign period      = (half_cnt == 16'd0) ? 16'd1 : half_cnt;

    // one-cycle tick every period cycles
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            tick_cnt <= '0;
            o_tick   <= 1'b0;
        end
        else if (half_cnt_wr)
        begin
            // new period, count again from zero
            tick_cnt <= '0;
            o_tick   <= 1'b0;
        end
        else if (tick_cnt >= period - 16'd1)
        begin
            tick_cnt <= '0;
            o_tick   <= 1'b1;
        end
        else
        begin
            tick_cnt <= tick_cnt + 16'd1;
            o_tick   <= 1'b0;
        end
    end

endmodule

// File: rtl/length_buffer.sv
`timescale 1ns/1ps

`include "joint_loop_macros.svh"

module length_buffer
(
    input  logic                    ep50trig,
    input  logic                    reset_global,
    input  logic                    i_sim_reset,
    input  logic                    i_pipe_write,
    input  joint_loop_pkg::sample_t i_pipe_data,
    input  logic                    i_tick,
    input  logic                    i_override_en,
    input  joint_loop_pkg::sample_t i_override_len,
    output joint_loop_pkg::sample_t o_len,
    output logic                    o_len_valid
);

    // sample memory, no reset
    joint_loop_pkg::sample_t mem [`WAVE_DEPTH];

    logic [`WAVE_AW-1:0] wr_ptr;
    logic [`WAVE_AW-1:0] rd_ptr;
    // occupancy, one bit wider than the pointers
    logic [`WAVE_AW:0]   fill;
    logic                clear;
    logic                full;
    logic                empty;
    logic                push;
    logic                pop;
    // last sample taken out of the memory
    joint_loop_pkg::sample_t last_pop;

    // sim reset clears pointers but not the host registers
    assign clear = reset_global || i_sim_reset;

    assign full  = (fill == `WAVE_DEPTH);
    assign empty = (fill == '0);
    // write into a full buffer is lost
    assign push  = i_pipe_write && !full;
    // tick on an empty buffer keeps last_pop
    assign pop   = i_tick && !empty;

    //////////////////////////////////////////////////
    // memory write port
    //////////////////////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (push)
        begin
            mem[wr_ptr] <= i_pipe_data;
        end
    end

    //////////////////////////////////////////////////
    // pointers and occupancy
    //////////////////////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (clear)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end
        else
        begin
            // pointers wrap on their own width
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                fill <= fill + 1'b1;
            else if (pop && !push)
                fill <= fill - 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // pop on tick
    //////////////////////////////////////////////////

    // oldest sample, held until the next pop
    always_ff @(posedge ep50trig)
    begin
        if (clear)
        begin
            last_pop    <= '0;
            o_len_valid <= 1'b0;
        end
        else
        begin
            if (pop)
                last_pop <= mem[rd_ptr];
            // valid follows every tick, even when empty
            o_len_valid <= i_tick;
        end
    end

    // override replaces the buffered length, pops go on
    assign o_len = i_override_en ? i_override_len : last_pop;

endmodule

// File: rtl/motor_pool.sv
`timescale 1ns/1ps

module motor_pool
(
    input  logic                    ep50trig,
    input  logic                    reset_global,
    input  logic                    i_sim_reset,
    input  joint_loop_pkg::sample_t i_len,
    input  logic                    i_len_valid,
    input  joint_loop_pkg::gain_t   i_gain,
    input  logic [31:0]             i_threshold,
    input  joint_loop_pkg::count_t  i_window,
    output logic                    o_spike,
    output joint_loop_pkg::count_t  o_spike_count,
    output logic                    o_count_valid
);

    logic                   clear;
    // input drive for this update
    joint_loop_pkg::drive_t drive;
    // membrane accumulator, keeps the remainder after a spike
    logic [32:0]            acc;
    // one extra bit so the compare sees the carry
    logic [33:0]            sum;
    logic [33:0]            sum_left;
    logic                   fire;
    // updates and spikes seen in the open window
    joint_loop_pkg::count_t upd_cnt;
    joint_loop_pkg::count_t spk_cnt;
    joint_loop_pkg::count_t spk_next;
    // window of zero acts as one
    joint_loop_pkg::count_t win_len;
    logic                   win_done;

    assign clear = reset_global || i_sim_reset;

    //////////////////////////////////////////////////
    // integrate and fire
    //////////////////////////////////////////////////

    // 16x16 product fits the 32-bit drive
    assign drive    = i_len * i_gain;
    assign sum      = {1'b0, acc} + {2'b00, drive};
    assign fire     = (sum >= {2'b00, i_threshold});
    assign sum_left = sum - {2'b00, i_threshold};

    always_ff @(posedge ep50trig)
    begin
        if (clear)
        begin
            acc     <= '0;
            o_spike <= 1'b0;
        end
        else if (i_len_valid)
        begin
            // at most one spike per update
            if (fire)
                acc <= sum_left[32:0];
            else
                acc <= sum[32:0];
            o_spike <= fire;
        end
        else
        begin
            o_spike <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // windowed spike counter
    //////////////////////////////////////////////////

    assign win_len  = (i_window == '0) ? 16'd1 : i_window;
    // last update of the window, compare avoids overflow on +1
    assign win_done = (upd_cnt >= win_len - 16'd1);
    // count includes the spike of this update
    assign spk_next = spk_cnt + {15'd0, fire};

    always_ff @(posedge ep50trig)
    begin
        if (clear)
        begin
            upd_cnt       <= '0;
            spk_cnt       <= '0;
            o_spike_count <= '0;
            o_count_valid <= 1'b0;
        end
        else if (i_len_valid)
        begin
            if (win_done)
            begin
                // report and open a new window
                o_spike_count <= spk_next;
                o_count_valid <= 1'b1;
                upd_cnt       <= '0;
                spk_cnt       <= '0;
            end
            else
            begin
                o_count_valid <= 1'b0;
                upd_cnt       <= upd_cnt + 16'd1;
                spk_cnt       <= spk_next;
            end
        end
        else
        begin
            // o_spike_count holds the last report
            o_count_valid <= 1'b0;
        end
    end

endmodule

// File: rtl/joint_loop_top.sv
`timescale 1ns/1ps

module joint_loop_top
(
    input  logic                        ep50trig,
    input  logic                        reset_global,
    input  logic                        i_sim_reset,
    input  logic                        i_trig_valid,
    input  joint_loop_pkg::param_addr_e i_trig_addr,
    input  logic [15:0]                 i_wire_lo,
    input  logic [15:0]                 i_wire_hi,
    input  logic                        i_pipe_write,
    input  joint_loop_pkg::sample_t     i_pipe_data,
    output joint_loop_pkg::sample_t     o_len,
    output logic                        o_len_valid,
    output logic                        o_spike,
    output joint_loop_pkg::count_t      o_spike_count,
    output logic                        o_count_valid
);

    // host registers out to the datapath
    logic                    tick;
    joint_loop_pkg::gain_t   gain;
    logic [31:0]             threshold;
    joint_loop_pkg::count_t  window;
    logic                    override_en;
    joint_loop_pkg::sample_t override_len;

    //////////////////////////////////////////////////
    // parameters and tick
    //////////////////////////////////////////////////

    host_control host_control_i
    (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .i_trig_valid   (i_trig_valid),
        .i_trig_addr    (i_trig_addr),
        .i_wire_lo      (i_wire_lo),
        .i_wire_hi      (i_wire_hi),
        .o_tick         (tick),
        .o_gain         (gain),
        .o_threshold    (threshold),
        .o_window       (window),
        .o_override_en  (override_en),
        .o_override_len (override_len)
    );

    // pipe samples in, one length per tick out
    length_buffer length_buffer_i
    (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .i_sim_reset    (i_sim_reset),
        .i_pipe_write   (i_pipe_write),
        .i_pipe_data    (i_pipe_data),
        .i_tick         (tick),
        .i_override_en  (override_en),
        .i_override_len (override_len),
        .o_len          (o_len),
        .o_len_valid    (o_len_valid)
    );

    // length to spikes and window counts
    motor_pool motor_pool_i
    (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_sim_reset   (i_sim_reset),
        .i_len         (o_len),
        .i_len_valid   (o_len_valid),
        .i_gain        (gain),
        .i_threshold   (threshold),
        .i_window      (window),
        .o_spike       (o_spike),
        .o_spike_count (o_spike_count),
        .o_count_valid (o_count_valid)
    );

endmodule

// File: test/joint_loop_asserts.sv
`timescale 1ns/1ps

`include "joint_loop_macros.svh"

module joint_loop_asserts
(
    input logic                        ep50trig,
    input logic                        reset_global,
    input logic                        i_sim_reset,
    input logic                        i_trig_valid,
    input joint_loop_pkg::param_addr_e i_trig_addr,
    input logic [15:0]                 i_wire_lo,
    input logic [15:0]                 i_wire_hi,
    input logic                        i_pipe_write,
    input joint_loop_pkg::sample_t     i_pipe_data,
    input joint_loop_pkg::sample_t     o_len,
    input logic                        o_len_valid,
    input logic                        o_spike,
    input joint_loop_pkg::count_t      o_spike_count,
    input logic                        o_count_valid
);

    // host register copies seen on the trigger bus
    logic [15:0] m_half, m_gain, m_win, m_ovr_len;
    logic [31:0] m_thr;
    logic        m_ovr_en;
    // model fifo, head and fill
    logic [15:0] m_fifo [0:`WAVE_DEPTH-1];
    logic [5:0]  m_head;
    logic [6:0]  m_count;
    logic        pushed_last;
    logic [15:0] m_last, m_upd, m_spk, m_cnt, gap, period, win_len;
    logic [32:0] m_acc;
    logic [33:0] m_sum;
    logic        m_spike, m_cnt_valid, have_ref, half_wr, half_wr_q, can_pop, fire;
    joint_loop_pkg::sample_t exp_len;
    int          fail_count = 0;

    assign half_wr = i_trig_valid && (i_trig_addr == joint_loop_pkg::PA_HALF_CNT);
    assign period  = (m_half == 16'd0) ? 16'd1 : m_half;
    assign win_len = (m_win == 16'd0) ? 16'd1 : m_win;
    // the pop was decided a cycle back, before the last push
    assign can_pop = m_count > {6'd0, pushed_last};
    assign exp_len = m_ovr_en ? m_ovr_len : (can_pop ? m_fifo[m_head] : m_last);
    assign m_sum   = m_acc + o_len * m_gain;
    assign fire    = m_sum >= {2'b00, m_thr};

    //////////////////////////////////////////////////
    // reference models
    //////////////////////////////////////////////////

    always @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            m_half   <= `DEF_HALF_CNT;
            m_gain   <= `DEF_GAIN;
            m_thr    <= `DEF_THRESHOLD;
            m_win    <= `DEF_WINDOW;
            m_ovr_en <= 1'b0;
            m_ovr_len <= '0;
        end
        else if (i_trig_valid)
        begin
            // unknown addresses fall through
            case (i_trig_addr)
                joint_loop_pkg::PA_HALF_CNT:     m_half    <= i_wire_lo;
                joint_loop_pkg::PA_GAIN:         m_gain    <= i_wire_lo;
                joint_loop_pkg::PA_THRESHOLD:    m_thr     <= {i_wire_hi, i_wire_lo};
                joint_loop_pkg::PA_LEN_OVERRIDE: m_ovr_len <= i_wire_lo;
                joint_loop_pkg::PA_OVERRIDE_EN:  m_ovr_en  <= i_wire_lo[0];
                joint_loop_pkg::PA_WINDOW:       m_win     <= i_wire_lo;
                default:
                begin
                end
            endcase
        end
    end

    always @(posedge ep50trig)
    begin
        logic [6:0] cnt;
        logic [5:0] hd;
        cnt       = m_count;
        hd        = m_head;
        gap       <= o_len_valid ? 16'd1 : gap + 16'd1;
        half_wr_q <= half_wr;
        if (reset_global || i_sim_reset)
        begin
            m_head      <= '0;
            m_count     <= '0;
            pushed_last <= 1'b0;
            m_last      <= '0;
            m_acc       <= '0;
            m_spike     <= 1'b0;
            m_upd       <= '0;
            m_spk       <= '0;
            m_cnt       <= '0;
            m_cnt_valid <= 1'b0;
            have_ref    <= 1'b0;
        end
        else
        begin
            // pop for the tick that made this pulse
            if (o_len_valid && can_pop)
            begin
                m_last <= m_fifo[hd];
                hd     = hd + 6'd1;
                cnt    = cnt - 7'd1;
            end
            // writes into 64 pending samples are lost
            pushed_last <= i_pipe_write && (cnt < 7'd64);
            if (i_pipe_write && (cnt < 7'd64))
            begin
                m_fifo[hd + cnt[5:0]] <= i_pipe_data;
                cnt = cnt + 7'd1;
            end
            m_head      <= hd;
            m_count     <= cnt;
            m_spike     <= o_len_valid && fire;
            m_cnt_valid <= 1'b0;
            if (o_len_valid)
            begin
                m_acc <= fire ? 33'(m_sum - {2'b00, m_thr}) : m_sum[32:0];
                if ({1'b0, m_upd} + 17'd1 >= {1'b0, win_len})
                begin
                    m_cnt       <= m_spk + {15'd0, fire};
                    m_cnt_valid <= 1'b1;
                    m_upd       <= '0;
                    m_spk       <= '0;
                end
                else
                begin
                    m_upd <= m_upd + 16'd1;
                    m_spk <= m_spk + {15'd0, fire};
                end
            end
            // first pulse after a period write may come from the old period
            if (half_wr)
                have_ref <= 1'b0;
            else if (o_len_valid)
                have_ref <= !half_wr_q;
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    a_tick_gap: assert property (@(posedge ep50trig) disable iff (reset_global || i_sim_reset)
        (o_len_valid && have_ref) |-> (gap == period))
    else
    begin
        fail_count++;
        $error("MISMATCH t=%0t o_len_valid gap exp %0d got %0d", $time,
            $sampled(period), $sampled(gap));
    end

    a_len: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_len_valid |-> (o_len == exp_len))
    else
    begin
        fail_count++;
        $error("MISMATCH t=%0t o_len exp %0d got %0d", $time, $sampled(exp_len),
            $sampled(o_len));
    end

    a_spike: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_spike == m_spike)
    else
    begin
        fail_count++;
        $error("MISMATCH t=%0t o_spike exp %0b got %0b", $time, $sampled(m_spike),
            $sampled(o_spike));
    end

    a_count_valid: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_count_valid == m_cnt_valid)
    else
    begin
        fail_count++;
        $error("MISMATCH t=%0t o_count_valid exp %0b got %0b", $time,
            $sampled(m_cnt_valid), $sampled(o_count_valid));
    end

    // count holds between reports too
    a_count: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_spike_count == m_cnt)
    else
    begin
        fail_count++;
        $error("MISMATCH t=%0t o_spike_count exp %0d got %0d", $time, $sampled(m_cnt),
            $sampled(o_spike_count));
    end

endmodule

// File: test/joint_loop_tb.sv
`timescale 1ns/1ps

module joint_loop_tb;

    // stimulus runs under 2000 cycles
    localparam int MAX_CYCLES = 4000;

    logic                        ep50trig = 1'b0;
    logic                        reset_global, i_sim_reset, i_trig_valid, i_pipe_write;
    joint_loop_pkg::param_addr_e i_trig_addr;
    logic [15:0]                 i_wire_lo, i_wire_hi;
    joint_loop_pkg::sample_t     i_pipe_data, o_len;
    logic                        o_len_valid, o_spike, o_count_valid;
    joint_loop_pkg::count_t      o_spike_count;
    logic [15:0]                 lfsr = 16'd68;
    int                          cycle_count = 0;

    always #5 ep50trig = ~ep50trig;

    joint_loop_top joint_loop_top_i (.*);

    // reference models ride inside the DUT
    bind joint_loop_top joint_loop_asserts joint_loop_asserts_i (.*);

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    // fibonacci lfsr, taps 16 14 13 11, one step per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] val;
        int          b;
        val = '0;
        for (b = 0; b < n; b++)
        begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            val  = {val[14:0], lfsr[0]};
        end
        return val;
    endfunction

    task automatic set_param(input joint_loop_pkg::param_addr_e addr, input logic [31:0] value);
        i_trig_valid           = 1'b1;
        i_trig_addr            = addr;
        {i_wire_hi, i_wire_lo} = value;
        @(negedge ep50trig);
        i_trig_valid = 1'b0;
    endtask

    // sparse mode writes on about half the cycles
    task automatic push_samples(input int n, input int bits, input logic sparse);
        repeat (n)
        begin
            i_pipe_write = sparse ? (rand_bits(1) != 16'd0) : 1'b1;
            i_pipe_data  = rand_bits(bits);
            @(negedge ep50trig);
        end
        i_pipe_write = 1'b0;
    endtask

    task automatic wait_pulses(input int n);
        int seen;
        seen = 0;
        while (seen < n)
        begin
            @(negedge ep50trig);
            if (o_len_valid)
                seen++;
        end
    endtask

    // cycle limit and error watch
    always @(negedge ep50trig)
    begin
        cycle_count <= cycle_count + 1;
        if (joint_loop_top_i.joint_loop_asserts_i.fail_count != 0)
        begin
            $display("=== FAIL ===");
            $fatal(1, "assertion failed by cycle %0d", cycle_count);
        end
        else if (cycle_count >= MAX_CYCLES)
        begin
            $display("=== FAIL ===");
            $fatal(1, "run did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial
    begin
        reset_global = 1'b1;
        i_sim_reset  = 1'b0;
        i_trig_valid = 1'b0;
        i_trig_addr  = joint_loop_pkg::PA_HALF_CNT;
        i_wire_lo    = '0;
        i_wire_hi    = '0;
        i_pipe_write = 1'b0;
        i_pipe_data  = '0;
        repeat (5) @(posedge ep50trig);
        @(negedge ep50trig);
        reset_global = 1'b0;
        // order, then empty repeats at period 3
        set_param(joint_loop_pkg::PA_HALF_CNT, 32'd3);
        set_param(joint_loop_pkg::PA_GAIN, 32'd3);
        set_param(joint_loop_pkg::PA_THRESHOLD, 32'd2000);
        set_param(joint_loop_pkg::param_addr_e'(4'hf), 32'hdead_beef);
        push_samples(20, 10, 1'b0);
        wait_pulses(30);
        // overfill while ticks are slow, then drain
        set_param(joint_loop_pkg::PA_HALF_CNT, 32'd200);
        push_samples(70, 10, 1'b0);
        set_param(joint_loop_pkg::PA_HALF_CNT, 32'd2);
        wait_pulses(72);
        // override hides the buffer, pops go on
        push_samples(12, 10, 1'b0);
        set_param(joint_loop_pkg::PA_LEN_OVERRIDE, 32'd555);
        set_param(joint_loop_pkg::PA_OVERRIDE_EN, 32'd1);
        wait_pulses(5);
        set_param(joint_loop_pkg::PA_OVERRIDE_EN, 32'd0);
        wait_pulses(10);
        // wide threshold, window 0 then 5, period 1 then 0
        set_param(joint_loop_pkg::PA_GAIN, 32'h0000_ffff);
        set_param(joint_loop_pkg::PA_THRESHOLD, 32'h0100_8000);
        set_param(joint_loop_pkg::PA_WINDOW, 32'd0);
        set_param(joint_loop_pkg::PA_HALF_CNT, 32'd1);
        push_samples(40, 8, 1'b1);
        set_param(joint_loop_pkg::PA_WINDOW, 32'd5);
        set_param(joint_loop_pkg::PA_HALF_CNT, 32'd0);
        push_samples(40, 8, 1'b1);
        // sim reset inside an open window
        set_param(joint_loop_pkg::PA_HALF_CNT, 32'd5);
        push_samples(20, 10, 1'b1);
        wait_pulses(3);
        i_sim_reset = 1'b1;
        repeat (2) @(negedge ep50trig);
        i_sim_reset = 1'b0;
        // long random run, buffer fills and drops
        push_samples(1200, 12, 1'b1);
        wait_pulses(20);
        if (joint_loop_top_i.joint_loop_asserts_i.fail_count == 0)
        begin
            $display("=== PASS ===");
            $finish;
        end
        else
        begin
            $display("=== FAIL ===");
            $fatal(1, "assertion failed at the end of the run");
        end
    end

endmodule

// File: list.f
+incdir+rtl
rtl/joint_loop_pkg.sv
rtl/host_control.sv
rtl/length_buffer.sv
rtl/motor_pool.sv
rtl/joint_loop_top.sv
test/joint_loop_asserts.sv
test/joint_loop_tb.sv

// File: Bender.yml
package:
  name: joint_loop

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/joint_loop_pkg.sv
      - rtl/host_control.sv
      - rtl/length_buffer.sv
      - rtl/motor_pool.sv
      - rtl/joint_loop_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/joint_loop_asserts.sv
      - test/joint_loop_tb.sv
